//--- list.f
+incdir+tb
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/stagePipe.sv
verilog/hazardUnit.sv
verilog/pipelineController.sv
tb/pipelineControllerTb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pipelineControllerTb -f list.f \
	&& { ./obj_dir/VpipelineControllerTb 2>&1 | tee sim.log; true; } \
	&& ! grep -q "Checks failed" sim.log \
	&& grep -q "All checks passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb/ctrlModel.svh
`ifndef ctrlModelSvh
`define ctrlModelSvh

////////////////////////////////////////
// reference pipeline state
////////////////////////////////////////

// decoded D fields, tNew counted from E
typedef struct packed {
	stageCtrlT ctrl;
	regAddrT   rs;
	regAddrT   rt;
	tickT      useRs;
	tickT      useRt;
	npcOpT     npc;
	logic      ext;
} refDecT;

logic [31:0] refD;
stageCtrlT refE;
stageCtrlT refM;
stageCtrlT refW;
regAddrT refERs;
regAddrT refERt;
regAddrT refMRt;
logic refStall;

function automatic refDecT decodeRef(logic [31:0] ins);
	refDecT d;
	logic [5:0] op;
	logic [5:0] fn;
	op = ins[31:26];
	fn = ins[5:0];
	d = '0;
	d.useRs = tUseNone;
	d.useRt = tUseNone;
	if (op == opR && fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt}) begin
		d.ctrl.dst = ins[15:11];
		d.ctrl.tNew = 2'd1;
		d.ctrl.aluOp = (fn == fnSubu) ? aluSub : (fn == fnAnd) ? aluAnd
			: (fn == fnOr) ? aluOr : (fn == fnSlt) ? aluSlt : aluAdd;
		d.useRs = 2'd1;
		d.useRt = 2'd1;
	end else if (op == opR && fn == fnJr) begin
		d.useRs = 2'd0;
		d.npc = npcJr;
	end else if (op inside {opAddi, opOri, opLui, opLw}) begin
		// immediate writers, result in rt
		d.ctrl.dst = ins[20:16];
		d.ctrl.tNew = (op == opLw) ? 2'd2 : 2'd1;
		d.ctrl.aluOp = (op == opOri) ? aluOr : (op == opLui) ? aluLui : aluAdd;
		d.ctrl.wdSel = (op == opLw) ? wdMem : wdAlu;
		d.ctrl.aluBSel = 1'b1;
		d.useRs = (op == opLui) ? tUseNone : 2'd1;
		d.ext = (op == opAddi) || (op == opLw);
	end else if (op == opSw) begin
		d.ctrl.memWr = 1'b1;
		d.ctrl.aluBSel = 1'b1;
		d.useRs = 2'd1;
		d.useRt = 2'd2;
		d.ext = 1'b1;
	end else if (op == opBeq) begin
		d.ctrl.aluOp = aluSub;
		d.useRs = 2'd0;
		d.useRt = 2'd0;
		d.npc = npcBranch;
	end else if (op == opJal) begin
		d.ctrl.dst = 5'd31;
		d.ctrl.wdSel = wdLink;
		d.ctrl.isLink = 1'b1;
		d.npc = npcJal;
	end
	d.ctrl.regWr = (d.ctrl.dst != 5'd0);
	d.rs = (d.useRs == tUseNone) ? 5'd0 : ins[25:21];
	d.rt = (d.useRt == tUseNone) ? 5'd0 : ins[20:16];
	return d;
endfunction

function automatic logic lateFor(regAddrT r, tickT tUse, stageCtrlT c);
	return (r != 5'd0) && (tUse != tUseNone) && c.regWr && (c.dst == r) && (c.tNew > tUse);
endfunction

function automatic logic stallRef(refDecT d);
	return lateFor(d.rs, d.useRs, refE) || lateFor(d.rs, d.useRs, refM)
		|| lateFor(d.rt, d.useRt, refE) || lateFor(d.rt, d.useRt, refM);
endfunction

// nearest writer after the reading stage
function automatic fwdSrcT fwdRef(regAddrT r, logic lookE, logic lookM);
	if (r == 5'd0) return fwdRf;
	if (lookE && refE.regWr && refE.dst == r) return refE.isLink ? fwdELink : fwdRf;
	if (lookM && refM.regWr && refM.dst == r) return (refM.wdSel == wdMem) ? fwdRf : fwdMRes;
	if (refW.regWr && refW.dst == r) return fwdWData;
	return fwdRf;
endfunction

function automatic stageCtrlT ageRef(stageCtrlT c);
	c.tNew = (c.tNew == 2'd0) ? 2'd0 : c.tNew - 2'd1;
	return c;
endfunction

task automatic resetRef();
	refD = 32'h0;
	refE = '0;
	refM = '0;
	refW = '0;
	refERs = 5'd0;
	refERt = 5'd0;
	refMRt = 5'd0;
	refStall = 1'b0;
endtask

// one rising edge of the pipeline
task automatic stepRef(logic [31:0] ins, logic valid);
	refDecT d;
	logic hold;
	d = decodeRef(refD);
	hold = stallRef(d);
	refW = ageRef(refM);
	refM = ageRef(refE);
	refMRt = refERt;
	refE = hold ? '0 : d.ctrl;
	refERs = hold ? 5'd0 : d.rs;
	refERt = hold ? 5'd0 : d.rt;
	if (!hold) refD = valid ? ins : 32'h0;
endtask

`endif

//--- tb/pipelineControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineControllerTb;
	import ctrlPkg::*;

	localparam int randomCycles = 4000;
	localparam int directedCycles = 19;
	localparam int directedStalls = 3;
	localparam int watchdogCycles = 5000;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic instrValid;
	logic stall;
	npcOpT npcOp;
	logic extSigned;
	fwdSrcT dRsFwd;
	fwdSrcT dRtFwd;
	aluOpT aluOp;
	logic aluBSel;
	fwdSrcT eRsFwd;
	fwdSrcT eRtFwd;
	logic memWr;
	fwdSrcT mRtFwd;
	logic regWr;
	wdSelT wdSel;
	regAddrT regWriteAddr;

	int seed;
	logic [31:0] offerInstr;
	logic offerValid;
	logic [31:0] directed[$];

	`include "ctrlModel.svh"

	pipelineController pipelineController_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic reportFailure(string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		assert (expected == actual)
			else reportFailure($sformatf("FAILED %s expected %0h actual %0h", name, expected, actual));
	endtask

	function automatic logic [31:0] encodeR(regAddrT rs, regAddrT rt, regAddrT rd, logic [5:0] fn);
		return {opR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, regAddrT rs, regAddrT rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// hazard sequences first, then random traffic on registers 0 to 3
	task automatic drawOffer();
		int kind;
		regAddrT a;
		regAddrT b;
		regAddrT c;
		logic [15:0] imm;
		if (directed.size() > 0) begin
			offerInstr = directed.pop_front();
			offerValid = 1'b1;
		end else begin
			offerValid = ($unsigned($random(seed)) % 10) < 8;
			kind = $unsigned($random(seed)) % 15;
			a = 5'($unsigned($random(seed)) % 4);
			b = 5'($unsigned($random(seed)) % 4);
			c = 5'($unsigned($random(seed)) % 4);
			imm = 16'($random(seed));
			case (kind)
				0: offerInstr = encodeR(a, b, c, fnAddu);
				1: offerInstr = encodeR(a, b, c, fnSubu);
				2: offerInstr = encodeR(a, b, c, fnAnd);
				3: offerInstr = encodeR(a, b, c, fnOr);
				4: offerInstr = encodeR(a, b, c, fnSlt);
				5: offerInstr = encodeI(opAddi, a, b, imm);
				6: offerInstr = encodeI(opOri, a, b, imm);
				7: offerInstr = encodeI(opLui, a, b, imm);
				8: offerInstr = encodeI(opLw, a, b, imm);
				9: offerInstr = encodeI(opSw, a, b, imm);
				10: offerInstr = encodeI(opBeq, a, b, imm);
				11: offerInstr = {opJal, 10'd0, imm};
				12: offerInstr = encodeR(a, 5'd0, 5'd0, fnJr);
				13: offerInstr = 32'h0;
				// unknown opcode
				default: offerInstr = {6'h3f, 26'($random(seed))};
			endcase
		end
	endtask

	task automatic compareOutputs();
		refDecT d;
		d = decodeRef(refD);
		refStall = stallRef(d);
		checkValue("stall", 32'(refStall), 32'(stall));
		checkValue("npcOp", 32'(d.npc), 32'(npcOp));
		checkValue("extSigned", 32'(d.ext), 32'(extSigned));
		checkValue("dRsFwd", 32'(fwdRef(d.rs, 1'b1, 1'b1)), 32'(dRsFwd));
		checkValue("dRtFwd", 32'(fwdRef(d.rt, 1'b1, 1'b1)), 32'(dRtFwd));
		checkValue("aluOp", 32'(refE.aluOp), 32'(aluOp));
		checkValue("aluBSel", 32'(refE.aluBSel), 32'(aluBSel));
		checkValue("eRsFwd", 32'(fwdRef(refERs, 1'b0, 1'b1)), 32'(eRsFwd));
		checkValue("eRtFwd", 32'(fwdRef(refERt, 1'b0, 1'b1)), 32'(eRtFwd));
		checkValue("memWr", 32'(refM.memWr), 32'(memWr));
		checkValue("mRtFwd", 32'(fwdRef(refMRt, 1'b0, 1'b0)), 32'(mRtFwd));
		checkValue("regWr", 32'(refW.regWr), 32'(regWr));
		checkValue("wdSel", 32'(refW.wdSel), 32'(wdSel));
		checkValue("regWriteAddr", 32'(refW.dst), 32'(regWriteAddr));
	endtask

	initial begin
		int count;
		for (count = 0; count < watchdogCycles; count++) @(posedge clk);
		reportFailure("run did not finish within the cycle limit");
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int cycle;
		int stallCount;
		seed = 32'h69b2a7d9;
		stallCount = 0;
		reset = 1'b1;
		instr = 32'h0;
		instrValid = 1'b0;
		// lw then ALU use, lw then beq, jal link, store data from W
		directed = '{encodeI(opLw, 5'd2, 5'd1, 16'h0), encodeR(5'd1, 5'd1, 5'd3, fnAddu),
			32'h0, 32'h0, 32'h0,
			encodeI(opLw, 5'd2, 5'd1, 16'h4), encodeI(opBeq, 5'd1, 5'd2, 16'h4),
			32'h0, 32'h0, 32'h0,
			{opJal, 26'h40}, encodeR(5'd31, 5'd0, 5'd3, fnAddu), encodeI(opSw, 5'd0, 5'd3, 16'h8),
			32'h0, 32'h0, 32'h0};
		resetRef();
		repeat (7) begin
			@(posedge clk);
			@(negedge clk);
			compareOutputs();
		end
		@(posedge clk);
		reset <= 1'b0;
		drawOffer();
		instr <= offerInstr;
		instrValid <= offerValid;
		@(negedge clk);
		compareOutputs();
		for (cycle = 0; cycle < directedCycles + randomCycles; cycle++) begin
			@(posedge clk);
			stepRef(offerInstr, offerValid);
			// a stalled offer stays on the bus
			if (!refStall) drawOffer();
			instr <= offerInstr;
			instrValid <= offerValid;
			@(negedge clk);
			compareOutputs();
			if (cycle < directedCycles && stall) stallCount++;
		end
		checkValue("directedStallCycles", directedStalls, stallCount);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////

	localparam logic [5:0] opR    = 6'h00;
	localparam logic [5:0] opJal  = 6'h03;
	localparam logic [5:0] opBeq  = 6'h04;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opOri  = 6'h0d;
	localparam logic [5:0] opLui  = 6'h0f;
	localparam logic [5:0] opLw   = 6'h23;
	localparam logic [5:0] opSw   = 6'h2b;

	// function field of opR
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	////////////////////////////////////////
	// basic types
	////////////////////////////////////////

	// register 0 is never written
	typedef logic [4:0] regAddrT;

	// stages until a result exists or an operand is needed
	typedef logic [1:0] tickT;

	localparam tickT tUseNone = 2'd3;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4,
		aluLui = 3'd5
	} aluOpT;

	typedef enum logic [1:0] {
		npcSeq    = 2'd0,
		npcBranch = 2'd1,
		npcJal    = 2'd2,
		npcJr     = 2'd3
	} npcOpT;

	// register file write data source
	typedef enum logic [1:0] {
		wdAlu  = 2'd0,
		wdMem  = 2'd1,
		wdLink = 2'd2
	} wdSelT;

	typedef enum logic [1:0] {
		fwdRf    = 2'd0,
		fwdELink = 2'd1,
		fwdMRes  = 2'd2,
		fwdWData = 2'd3
	} fwdSrcT;

	////////////////////////////////////////
	// per-stage control record
	////////////////////////////////////////

	// aluBSel high takes the extended immediate as ALU operand B
	typedef struct packed {
		regAddrT dst;
		tickT    tNew;
		logic    regWr;
		logic    memWr;
		wdSelT   wdSel;
		aluOpT   aluOp;
		logic    aluBSel;
		logic    isLink;
	} stageCtrlT;

	localparam stageCtrlT bubbleCtrl = '0;

endpackage

`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  wire ctrlPkg::stageCtrlT  dCtrl,
	input  wire ctrlPkg::stageCtrlT  eCtrl,
	input  wire ctrlPkg::stageCtrlT  mCtrl,
	input  wire ctrlPkg::stageCtrlT  wCtrl,
	input  wire ctrlPkg::regAddrT    dRs,
	input  wire ctrlPkg::regAddrT    dRt,
	input  wire ctrlPkg::regAddrT    eRs,
	input  wire ctrlPkg::regAddrT    eRt,
	input  wire ctrlPkg::regAddrT    mRt,
	input  wire ctrlPkg::tickT       tUseRs,
	input  wire ctrlPkg::tickT       tUseRt,
	output logic                     stall,
	output ctrlPkg::fwdSrcT          dRsFwd,
	output ctrlPkg::fwdSrcT          dRtFwd,
	output ctrlPkg::fwdSrcT          eRsFwd,
	output ctrlPkg::fwdSrcT          eRtFwd,
	output ctrlPkg::fwdSrcT          mRtFwd
);
	import ctrlPkg::*;

	// stage c will write register r
	function automatic logic writes(regAddrT r, stageCtrlT c);
		return (r != '0) && c.regWr && (c.dst == r);
	endfunction

	// result arrives too late for the operand
	function automatic logic waits(regAddrT r, tickT tUse, stageCtrlT c);
		return writes(r, c) && (tUse != tUseNone) && (c.tNew > tUse);
	endfunction

	// nearest younger writer wins
	// only jal has its value ready in E, a load in M is covered by the stall
	function automatic fwdSrcT nearest(regAddrT r, logic seeE, logic seeM,
			stageCtrlT e, stageCtrlT m, stageCtrlT w);
		fwdSrcT src;
		src = fwdRf;
		if (seeE && writes(r, e)) begin
			src = e.isLink ? fwdELink : fwdRf;
		end else if (seeM && writes(r, m)) begin
			src = (m.wdSel == wdMem) ? fwdRf : fwdMRes;
		end else if (writes(r, w)) begin
			src = fwdWData;
		end
		return src;
	endfunction

	////////////////////////////////////////
	// stall
	////////////////////////////////////////

	always_comb begin
		stall = waits(dRs, tUseRs, eCtrl) || waits(dRs, tUseRs, mCtrl)
			|| waits(dRt, tUseRt, eCtrl) || waits(dRt, tUseRt, mCtrl);
	end

	////////////////////////////////////////
	// forwarding selects
	////////////////////////////////////////

	always_comb begin
		dRsFwd = nearest(dRs, 1'b1, 1'b1, eCtrl, mCtrl, wCtrl);
		dRtFwd = nearest(dRt, 1'b1, 1'b1, eCtrl, mCtrl, wCtrl);
		eRsFwd = nearest(eRs, 1'b0, 1'b1, eCtrl, mCtrl, wCtrl);
		eRtFwd = nearest(eRt, 1'b0, 1'b1, eCtrl, mCtrl, wCtrl);
		// store data in M only sees W
		mRtFwd = nearest(mRt, 1'b0, 1'b0, eCtrl, mCtrl, wCtrl);
	end

	// the register compares above rely on writers never targeting $0
	always_comb begin
		assert (!dCtrl.regWr || (dCtrl.dst != '0))
			else $error("decoded writer targets register 0");
		assert (!stall || (tUseRs != tUseNone) || (tUseRt != tUseNone))
			else $error("stall without any operand read in D");
		assert (((dRs != '0) || (dRsFwd == fwdRf)) && ((dRt != '0) || (dRtFwd == fwdRf))
			&& ((eRs != '0) || (eRsFwd == fwdRf)) && ((eRt != '0) || (eRtFwd == fwdRf))
			&& ((mRt != '0) || (mRtFwd == fwdRf)))
			else $error("forward selected for register 0");
	end

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  wire logic [31:0]     dInstr,
	output ctrlPkg::stageCtrlT   dCtrl,
	output ctrlPkg::regAddrT     dRs,
	output ctrlPkg::regAddrT     dRt,
	output ctrlPkg::tickT        tUseRs,
	output ctrlPkg::tickT        tUseRt,
	output ctrlPkg::npcOpT       npcOp,
	output logic                 extSigned
);
	import ctrlPkg::*;

	logic [5:0] op;
	logic [5:0] fn;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	logic isAluR;
	aluOpT rAluOp;
	stageCtrlT ctrl;

	assign op = dInstr[31:26];
	assign fn = dInstr[5:0];
	assign rs = dInstr[25:21];
	assign rt = dInstr[20:16];
	assign rd = dInstr[15:11];

	assign isAluR = (op == opR) && (fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt});

	always_comb begin
		case (fn)
			fnSubu: rAluOp = aluSub;
			fnAnd: rAluOp = aluAnd;
			fnOr: rAluOp = aluOr;
			fnSlt: rAluOp = aluSlt;
			default: rAluOp = aluAdd;
		endcase
	end

	// tNew is counted from D, so it reads one less once in E
	always_comb begin
		ctrl = bubbleCtrl;
		tUseRs = tUseNone;
		tUseRt = tUseNone;
		npcOp = npcSeq;
		extSigned = 1'b0;
		case (op)
			opR: begin
				if (fn == fnJr) begin
					tUseRs = 2'd0;
					npcOp = npcJr;
				end else if (isAluR) begin
					ctrl.dst = rd;
					ctrl.tNew = 2'd2;
					ctrl.regWr = 1'b1;
					ctrl.aluOp = rAluOp;
					tUseRs = 2'd1;
					tUseRt = 2'd1;
				end
			end
			opAddi, opOri: begin
				ctrl.dst = rt;
				ctrl.tNew = 2'd2;
				ctrl.regWr = 1'b1;
				ctrl.aluOp = (op == opOri) ? aluOr : aluAdd;
				ctrl.aluBSel = 1'b1;
				tUseRs = 2'd1;
				extSigned = (op == opAddi);
			end
			opLui: begin
				ctrl.dst = rt;
				ctrl.tNew = 2'd2;
				ctrl.regWr = 1'b1;
				ctrl.aluOp = aluLui;
				ctrl.aluBSel = 1'b1;
			end
			opLw: begin
				ctrl.dst = rt;
				ctrl.tNew = 2'd3;
				ctrl.regWr = 1'b1;
				ctrl.wdSel = wdMem;
				ctrl.aluBSel = 1'b1;
				tUseRs = 2'd1;
				extSigned = 1'b1;
			end
			opSw: begin
				ctrl.memWr = 1'b1;
				ctrl.aluBSel = 1'b1;
				tUseRs = 2'd1;
				// store data is only needed in M
				tUseRt = 2'd2;
				extSigned = 1'b1;
			end
			opBeq: begin
				ctrl.aluOp = aluSub;
				tUseRs = 2'd0;
				tUseRt = 2'd0;
				npcOp = npcBranch;
			end
			opJal: begin
				// link goes to $ra
				ctrl.dst = 5'd31;
				ctrl.regWr = 1'b1;
				ctrl.wdSel = wdLink;
				ctrl.isLink = 1'b1;
				npcOp = npcJal;
			end
			default: begin
				ctrl = bubbleCtrl;
			end
		endcase
		if (ctrl.dst == '0) begin
			ctrl.regWr = 1'b0;
		end
	end

	assign dCtrl = ctrl;

	// fields that are not read are reported as register 0
	assign dRs = (tUseRs != tUseNone) ? rs : '0;
	assign dRt = (tUseRt != tUseNone) ? rt : '0;

endmodule

`default_nettype wire

//--- verilog/pipelineController.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineController (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic [31:0]   instr,
	input  wire logic          instrValid,
	output logic               stall,
	output ctrlPkg::npcOpT     npcOp,
	output logic               extSigned,
	output ctrlPkg::fwdSrcT    dRsFwd,
	output ctrlPkg::fwdSrcT    dRtFwd,
	output ctrlPkg::aluOpT     aluOp,
	output logic               aluBSel,
	output ctrlPkg::fwdSrcT    eRsFwd,
	output ctrlPkg::fwdSrcT    eRtFwd,
	output logic               memWr,
	output ctrlPkg::fwdSrcT    mRtFwd,
	output logic               regWr,
	output ctrlPkg::wdSelT     wdSel,
	output ctrlPkg::regAddrT   regWriteAddr
);
	import ctrlPkg::*;

	logic [31:0] dInstr;
	stageCtrlT dCtrl;
	stageCtrlT eCtrl;
	stageCtrlT mCtrl;
	stageCtrlT wCtrl;
	regAddrT dRs;
	regAddrT dRt;
	regAddrT eRs;
	regAddrT eRt;
	regAddrT mRt;
	tickT tUseRs;
	tickT tUseRt;

	stagePipe stagePipe_inst (.*);

	instrDecoder instrDecoder_inst (.*);

	hazardUnit hazardUnit_inst (.*);

	////////////////////////////////////////
	// per-stage outputs
	////////////////////////////////////////

	// execute
	assign aluOp = eCtrl.aluOp;
	assign aluBSel = eCtrl.aluBSel;

	// memory
	assign memWr = mCtrl.memWr;

	// writeback
	assign regWr = wCtrl.regWr;
	assign wdSel = wCtrl.wdSel;
	assign regWriteAddr = wCtrl.dst;

endmodule

`default_nettype wire

//--- verilog/stagePipe.sv
`timescale 1ns/1ps
`default_nettype none

module stagePipe (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic [31:0]         instr,
	input  wire logic                instrValid,
	input  wire logic                stall,
	input  wire ctrlPkg::stageCtrlT  dCtrl,
	input  wire ctrlPkg::regAddrT    dRs,
	input  wire ctrlPkg::regAddrT    dRt,
	output logic [31:0]              dInstr,
	output ctrlPkg::stageCtrlT       eCtrl,
	output ctrlPkg::stageCtrlT       mCtrl,
	output ctrlPkg::stageCtrlT       wCtrl,
	output ctrlPkg::regAddrT         eRs,
	output ctrlPkg::regAddrT         eRt,
	output ctrlPkg::regAddrT         mRt
);
	import ctrlPkg::*;

	// one stage closer to its result, saturating at zero
	function automatic stageCtrlT advance(stageCtrlT c);
		stageCtrlT n;
		n = c;
		if (n.tNew != '0) begin
			n.tNew = n.tNew - 2'd1;
		end
		return n;
	endfunction

	////////////////////////////////////////
	// D register
	////////////////////////////////////////

	// idle cycles load a nop, a stall holds the instruction
	always_ff @(posedge clk) begin
		if (reset) begin
			dInstr <= '0;
		end else if (!stall) begin
			dInstr <= instrValid ? instr : 32'h0;
		end
	end

	////////////////////////////////////////
	// E, M and W records
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			eCtrl <= bubbleCtrl;
			mCtrl <= bubbleCtrl;
			wCtrl <= bubbleCtrl;
			eRs <= '0;
			eRt <= '0;
			mRt <= '0;
		end else begin
			if (stall) begin
				eCtrl <= bubbleCtrl;
				eRs <= '0;
				eRt <= '0;
			end else begin
				eCtrl <= advance(dCtrl);
				eRs <= dRs;
				eRt <= dRt;
			end
			mCtrl <= advance(eCtrl);
			mRt <= eRt;
			wCtrl <= advance(mCtrl);
		end
	end

	// a stalled cycle must leave a harmless bubble behind in E
	bubbleNoWrite: assert property (@(posedge clk) disable iff (reset)
		stall |=> (!eCtrl.regWr && !eCtrl.memWr));

	// loads are the slowest producer, two stages left once in E
	eTNewBound: assert property (@(posedge clk) disable iff (reset)
		eCtrl.tNew <= 2'd2);

endmodule

`default_nettype wire
